//--- build.f
+incdir+include
source/subcarrier_pkg.sv
source/subcarrier_csr.sv
source/dac_output_stage.sv
source/decoder_source_select.sv
source/reset_stretch.sv
source/subcarrier_top.sv
dv/tb_clock_gen.sv
dv/tb_checker.sv
dv/tb_subcarrier.sv

//--- dv/tb_checker.sv
`timescale 1ns/1ps
`default_nettype none
`include "subcarrier_macros.svh"

module tb_checker (
  input  wire logic                         ck933_i,
  input  wire logic                         rs_i,
  input  wire subcarrier_pkg::axil_req_t    req_i,
  input  wire subcarrier_pkg::axil_rsp_t    rsp_i,
  input  wire subcarrier_pkg::dac_word_t    ext_dac_i [3],
  input  wire subcarrier_pkg::dac_word_t    demod_dac_i [3],
  input  wire subcarrier_pkg::sym_bundle_t  ext_sym_i,
  input  wire subcarrier_pkg::sym_bundle_t  demod_sym_i,
  input  wire subcarrier_pkg::dac_word_t    dac_d_i [3],
  input  wire logic                         dac_rst_i,
  input  wire subcarrier_pkg::sym_bundle_t  dec_sym_i,
  input  wire subcarrier_pkg::boot_addr_t   boot_addr_i,
  input  wire logic                         reboot_i,
  input  wire subcarrier_pkg::axil_data_t   exp_rdata_i,
  output int                                err_cnt_o
);
  import subcarrier_pkg::*;

  dac_word_t    ext_h [3][3];    // [age][channel], age 0 is last cycle
  dac_word_t    demod_h [3][3];
  sym_bundle_t  ext_sym_h [2];
  sym_bundle_t  demod_sym_h [2];
  route_cfg_t   cfg_h [2];
  route_cfg_t   cfg_m;           // register model
  boot_addr_t   boot_m;
  logic         reboot_m;
  logic         rst_arm;
  logic         wr_busy;         // write response owed
  logic         rd_busy;         // read response owed
  logic         exp_wr_hs;
  logic         exp_rd_hs;
  int           rst_left;
  int           fill;
  dac_word_t    exp_w;
  sym_bundle_t  exp_s;

  task automatic flag_mismatch(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
    err_cnt_o++;
    $display("** Error at %0d ns: %s got %h expected %h", $time, what, got, exp);
  endtask

  function automatic dac_src_t src_of(input route_cfg_t c, input int ch);
    case (ch)
      0:       return c.dac0_src;
      1:       return c.dac1_src;
      default: return c.dac2_src;
    endcase
  endfunction

  function automatic dac_word_t expected_dac(input dac_src_t s, input dac_word_t e,
                                             input dac_word_t d);
    dac_word_t w;
    case (s)
      2'd0:    w = e;
      2'd1:    w = d;
      default: w = '0;
    endcase
    w[`SC_DAC_W-1] = ~w[`SC_DAC_W-1];  // offset binary
    return w;
  endfunction

  // **********************************************************
  // compare at the falling edge, then step the model
  // **********************************************************
  always @(negedge ck933_i) begin
    if (rs_i) begin
      err_cnt_o = 0;
      fill      = 0;
      cfg_m     = '0;
      boot_m    = '0;
      reboot_m  = 1'b0;
      rst_arm   = 1'b0;
      wr_busy   = 1'b0;
      rd_busy   = 1'b0;
      rst_left  = 0;
    end else begin
      // bus handshake model, one transaction at a time, write first
      exp_wr_hs = !wr_busy && !rd_busy && req_i.awvalid && req_i.wvalid;
      exp_rd_hs = !wr_busy && !rd_busy && req_i.arvalid
                  && !req_i.awvalid && !req_i.wvalid;
      if (rsp_i.awready !== exp_wr_hs)
        flag_mismatch("awready", 32'(rsp_i.awready), 32'(exp_wr_hs));
      if (rsp_i.wready !== exp_wr_hs)
        flag_mismatch("wready", 32'(rsp_i.wready), 32'(exp_wr_hs));
      if (rsp_i.arready !== exp_rd_hs)
        flag_mismatch("arready", 32'(rsp_i.arready), 32'(exp_rd_hs));
      if (rsp_i.bvalid !== wr_busy)
        flag_mismatch("bvalid", 32'(rsp_i.bvalid), 32'(wr_busy));
      if (rsp_i.rvalid !== rd_busy)
        flag_mismatch("rvalid", 32'(rsp_i.rvalid), 32'(rd_busy));

      if (dac_rst_i !== (rst_left != 0))
        flag_mismatch("dac_rst_o", 32'(dac_rst_i), 32'(rst_left != 0));
      if (reboot_i !== reboot_m)
        flag_mismatch("reboot_o", 32'(reboot_i), 32'(reboot_m));
      if (boot_addr_i !== boot_m)
        flag_mismatch("boot_addr_o", 32'(boot_addr_i), 32'(boot_m));
      if (fill >= 3) begin
        for (int ch = 0; ch < 3; ch++) begin
          exp_w = expected_dac(src_of(cfg_h[1], ch), ext_h[2][ch], demod_h[2][ch]);
          if (dac_d_i[ch] !== exp_w)
            flag_mismatch($sformatf("dac_d_o[%0d]", ch), 32'(dac_d_i[ch]), 32'(exp_w));
        end
      end
      if (fill >= 2) begin
        exp_s = cfg_h[0].dec_from_demod ? demod_sym_h[1] : ext_sym_h[1];
        if (dec_sym_i !== exp_s)
          flag_mismatch("dec_sym_o", {28'd0, dec_sym_i}, {28'd0, exp_s});
      end
      if (rsp_i.bvalid && req_i.bready && rsp_i.bresp !== 2'b00)
        flag_mismatch("bresp", 32'(rsp_i.bresp), 32'd0);
      if (rsp_i.rvalid && req_i.rready) begin
        if (rsp_i.rdata !== exp_rdata_i)
          flag_mismatch($sformatf("rdata @%h", req_i.araddr), rsp_i.rdata, exp_rdata_i);
        if (rsp_i.rresp !== 2'b00)
          flag_mismatch("rresp", 32'(rsp_i.rresp), 32'd0);
      end

      // responses close on ready and open the cycle after the handshake
      if (wr_busy && req_i.bready)
        wr_busy = 1'b0;
      if (rd_busy && req_i.rready)
        rd_busy = 1'b0;
      if (exp_wr_hs)
        wr_busy = 1'b1;
      if (exp_rd_hs)
        rd_busy = 1'b1;

      // shift the input and config history
      for (int ch = 0; ch < 3; ch++) begin
        ext_h[2][ch]   = ext_h[1][ch];
        ext_h[1][ch]   = ext_h[0][ch];
        ext_h[0][ch]   = ext_dac_i[ch];
        demod_h[2][ch] = demod_h[1][ch];
        demod_h[1][ch] = demod_h[0][ch];
        demod_h[0][ch] = demod_dac_i[ch];
      end
      ext_sym_h[1]   = ext_sym_h[0];
      ext_sym_h[0]   = ext_sym_i;
      demod_sym_h[1] = demod_sym_h[0];
      demod_sym_h[0] = demod_sym_i;
      cfg_h[1]       = cfg_h[0];
      cfg_h[0]       = cfg_m;

      if (rst_arm)
        rst_left = `SC_RESET_STRETCH;  // a new request restarts the stretch
      else if (rst_left > 0)
        rst_left--;
      rst_arm  = 1'b0;
      reboot_m = 1'b0;

      // write handshake seen this cycle lands at the next edge
      if (exp_wr_hs) begin
        case (req_i.awaddr)
          `SC_REG_RESET:   rst_arm = 1'b1;
          `SC_REG_DAC_SEL: begin
            cfg_m.dac0_src = req_i.wdata[1:0];
            cfg_m.dac1_src = req_i.wdata[3:2];
            cfg_m.dac2_src = req_i.wdata[5:4];
          end
          `SC_REG_DEC_SEL: cfg_m.dec_from_demod = req_i.wdata[0];
          `SC_REG_REBOOT: begin
            for (int b = 0; b < 3; b++) begin
              if (req_i.wstrb[b])
                boot_m[8*b +: 8] = req_i.wdata[8*b +: 8];
            end
            reboot_m = req_i.wstrb[2];
          end
          default: ;
        endcase
      end
      if (fill < 3)
        fill++;
    end
  end

endmodule

`default_nettype wire

//--- dv/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
  output logic ck933_o,
  output logic rs_o
);

  initial begin
    ck933_o = 1'b0;
    rs_o    = 1'b1;
    repeat (2) @(posedge ck933_o);
    #1 rs_o = 1'b0;  // release just after the second edge
  end

  always #2 ck933_o = ~ck933_o;  // 4 ns period

endmodule

`default_nettype wire

//--- dv/tb_subcarrier.sv
`timescale 1ns/1ps
`default_nettype none
`include "subcarrier_macros.svh"

module tb_subcarrier;
  import subcarrier_pkg::*;

  typedef enum logic [1:0] {
    OP_WR,
    OP_RD,
    OP_SAMPLE,
    OP_IDLE
  } op_e;

  typedef struct packed {
    op_e         op;
    axil_addr_t  addr;
    axil_data_t  data;
    logic [3:0]  strb;
    axil_data_t  exp;   // expected read data
    logic [3:0]  hold;  // back-pressure cycles, or length of sample/idle rows
  } row_t;

  localparam int NUM_ROWS = 20;
  localparam int TIMEOUT  = NUM_ROWS * 20 + 100;

  logic         ck933;
  logic         rs;
  axil_req_t    req;
  axil_rsp_t    rsp;
  dac_word_t    ext_dac [3];
  dac_word_t    demod_dac [3];
  dac_word_t    dac_d [3];
  sym_bundle_t  ext_sym;
  sym_bundle_t  demod_sym;
  sym_bundle_t  dec_sym;
  logic         dac_rst;
  logic         reboot;
  boot_addr_t   boot_addr;
  axil_data_t   exp_rdata;
  int           err_cnt;
  int           cyc = 0;
  logic [31:0]  lfsr_q;
  row_t         stim [NUM_ROWS];

  tb_clock_gen u_clk (.ck933_o(ck933), .rs_o(rs));

  subcarrier_top uut (
    .ck933        (ck933),
    .rs           (rs),
    .s_axil_req_i (req),
    .s_axil_rsp_o (rsp),
    .ext_dac_i    (ext_dac),
    .demod_dac_i  (demod_dac),
    .ext_sym_i    (ext_sym),
    .demod_sym_i  (demod_sym),
    .dac_d_o      (dac_d),
    .dac_rst_o    (dac_rst),
    .dec_sym_o    (dec_sym),
    .boot_addr_o  (boot_addr),
    .reboot_o     (reboot)
  );

  tb_checker u_check (
    .ck933_i     (ck933),
    .rs_i        (rs),
    .req_i       (req),
    .rsp_i       (rsp),
    .ext_dac_i   (ext_dac),
    .demod_dac_i (demod_dac),
    .ext_sym_i   (ext_sym),
    .demod_sym_i (demod_sym),
    .dac_d_i     (dac_d),
    .dac_rst_i   (dac_rst),
    .dec_sym_i   (dec_sym),
    .boot_addr_i (boot_addr),
    .reboot_i    (reboot),
    .exp_rdata_i (exp_rdata),
    .err_cnt_o   (err_cnt)
  );

  // fibonacci lfsr, taps 32 22 2 1, one step per bit
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      v      = {v[30:0], fb};
    end
    return v;
  endfunction

  // fresh samples on every cycle, 1 ns after the edge
  task automatic next_cycle();
    @(posedge ck933);
    #1;
    for (int ch = 0; ch < 3; ch++) begin
      ext_dac[ch]   = dac_word_t'(take_bits(`SC_DAC_W));
      demod_dac[ch] = dac_word_t'(take_bits(`SC_DAC_W));
    end
    ext_sym   = sym_bundle_t'(take_bits(4));
    demod_sym = sym_bundle_t'(take_bits(4));
  endtask

  task automatic write_reg(input row_t r);
    req.awaddr  = r.addr;
    req.wdata   = r.data;
    req.wstrb   = r.strb;
    req.awvalid = 1'b1;
    req.wvalid  = 1'b1;
    do @(negedge ck933); while (!rsp.awready);
    next_cycle();
    req.awvalid = 1'b0;
    req.wvalid  = 1'b0;
    repeat (r.hold) next_cycle();  // bready low
    req.bready = 1'b1;
    do @(negedge ck933); while (!rsp.bvalid);
    next_cycle();
    req.bready = 1'b0;
  endtask

  task automatic read_reg(input row_t r);
    exp_rdata   = r.exp;
    req.araddr  = r.addr;
    req.arvalid = 1'b1;
    do @(negedge ck933); while (!rsp.arready);
    next_cycle();
    req.arvalid = 1'b0;
    repeat (r.hold) next_cycle();  // rready low
    req.rready = 1'b1;
    do @(negedge ck933); while (!rsp.rvalid);
    next_cycle();
    req.rready = 1'b0;
  endtask

  always @(posedge ck933) begin
    cyc <= cyc + 1;
    if (cyc >= TIMEOUT) begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT);
      $display("TEST FAIL");
      $finish;
    end
  end

  initial begin
    req       = '0;
    ext_sym   = '0;
    demod_sym = '0;
    exp_rdata = '0;
    lfsr_q    = 32'h647c_b653;
    foreach (ext_dac[ch]) begin
      ext_dac[ch]   = '0;
      demod_dac[ch] = '0;
    end
    // ************************************************************
    // stimulus table
    // ************************************************************
    stim[0]  = '{OP_RD, `SC_REG_VERSION, 32'h0, 4'h0, 32'h0178_0000, 4'd3};
    stim[1]  = '{OP_RD, 8'h1C, 32'h0, 4'h0, 32'h0, 4'd2};  // unmapped
    stim[2]  = '{OP_RD, `SC_REG_DEC_SEL, 32'h0, 4'h0, 32'h0, 4'd0};
    stim[3]  = '{OP_SAMPLE, 8'h00, 32'h0, 4'h0, 32'h0, 4'd8};
    stim[4]  = '{OP_WR, `SC_REG_DAC_SEL, 32'h0000_0024, 4'hF, 32'h0, 4'd2};
    stim[5]  = '{OP_WR, `SC_REG_DEC_SEL, 32'h0000_0001, 4'hF, 32'h0, 4'd0};
    stim[6]  = '{OP_RD, `SC_REG_DAC_SEL, 32'h0, 4'h0, 32'h0001_0024, 4'd0};
    stim[7]  = '{OP_RD, `SC_REG_DEC_SEL, 32'h0, 4'h0, 32'h0001_0024, 4'd1};
    stim[8]  = '{OP_SAMPLE, 8'h00, 32'h0, 4'h0, 32'h0, 4'd8};
    stim[9]  = '{OP_WR, `SC_REG_DAC_SEL, 32'h0000_000D, 4'hF, 32'h0, 4'd0};
    stim[10] = '{OP_WR, `SC_REG_DEC_SEL, 32'hFFFF_FFFE, 4'hF, 32'h0, 4'd0};
    stim[11] = '{OP_RD, `SC_REG_DEC_SEL, 32'h0, 4'h0, 32'h0000_000D, 4'd0};
    stim[12] = '{OP_SAMPLE, 8'h00, 32'h0, 4'h0, 32'h0, 4'd8};
    stim[13] = '{OP_WR, `SC_REG_RESET, 32'hFFFF_FFFF, 4'hF, 32'h0, 4'd1};
    stim[14] = '{OP_IDLE, 8'h00, 32'h0, 4'h0, 32'h0, 4'd10};
    stim[15] = '{OP_WR, `SC_REG_REBOOT, 32'h00A5_C3E7, 4'h1, 32'h0, 4'd0};
    stim[16] = '{OP_WR, `SC_REG_REBOOT, 32'h00A5_C3E7, 4'h2, 32'h0, 4'd0};
    stim[17] = '{OP_RD, `SC_REG_REBOOT, 32'h0, 4'h0, 32'h0000_C3E7, 4'd0};
    stim[18] = '{OP_WR, `SC_REG_REBOOT, 32'h005A_0000, 4'h4, 32'h0, 4'd2};
    stim[19] = '{OP_RD, `SC_REG_REBOOT, 32'h0, 4'h0, 32'h005A_C3E7, 4'd2};

    @(negedge rs);
    next_cycle();
    for (int i = 0; i < NUM_ROWS; i++) begin
      case (stim[i].op)
        OP_WR:   write_reg(stim[i]);
        OP_RD:   read_reg(stim[i]);
        default: repeat (stim[i].hold) next_cycle();
      endcase
    end
    repeat (4) next_cycle();  // let the pipelines drain
    $display("summary: %0d rows applied, %0d errors", NUM_ROWS, err_cnt);
    if (err_cnt == 0)
      $display("TEST PASS");
    else
      $display("TEST FAIL");
    $finish;
  end

endmodule

`default_nettype wire

//--- include/subcarrier_macros.svh
`ifndef SUBCARRIER_MACROS_SVH
`define SUBCARRIER_MACROS_SVH

// **********************************************************
// bus and datapath widths
// **********************************************************
`define SC_ADDR_W        8
`define SC_DATA_W        32
`define SC_DAC_W         14
`define SC_BOOT_W        24

// version word, read back in the upper half
`define SC_VERSION       16'h0178

// dac reset length in ck933 cycles
`define SC_RESET_STRETCH 6

// **********************************************************
// register map, byte offsets
// **********************************************************
`define SC_REG_VERSION   8'h00
`define SC_REG_RESET     8'h04
`define SC_REG_DAC_SEL   8'h08
`define SC_REG_DEC_SEL   8'h0C
`define SC_REG_REBOOT    8'h10

`endif

//--- run_sim.sh
#!/usr/bin/env bash
# compile and run the subcarrier testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal -f build.f \
    --top-module tb_subcarrier -Mdir obj_dir -o tb_subcarrier; then
  echo "verilator compile failed"
  exit 1
fi

out=$(./obj_dir/tb_subcarrier)
status=$?
echo "$out"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "TEST PASS"; then
  exit 0
fi
exit 1

//--- source/dac_output_stage.sv
`timescale 1ns/1ps
`default_nettype none
`include "subcarrier_macros.svh"

module dac_output_stage (
  input  wire logic                        ck933,
  input  wire logic                        rs,
  input  wire subcarrier_pkg::route_cfg_t  route_cfg_i,
  input  wire subcarrier_pkg::dac_word_t   ext_dac_i [3],
  input  wire subcarrier_pkg::dac_word_t   demod_dac_i [3],
  output subcarrier_pkg::dac_word_t        dac_d_o [3]
);
  import subcarrier_pkg::*;

  localparam int NUM_DAC = 3;
  localparam int MSB     = `SC_DAC_W - 1;

  dac_src_t src [NUM_DAC];

  assign src[0] = route_cfg_i.dac0_src;
  assign src[1] = route_cfg_i.dac1_src;
  assign src[2] = route_cfg_i.dac2_src;

  // **********************************************************
  // per channel: reclock, mux, offset binary out
  // **********************************************************
  for (genvar ch = 0; ch < NUM_DAC; ch++) begin : g_ch
    dac_word_t ext_q;
    dac_word_t demod_q;
    dac_word_t mux_q;
    dac_word_t out_q;

    always_ff @(posedge ck933) begin
      ext_q   <= ext_dac_i[ch];
      demod_q <= demod_dac_i[ch];
      case (src[ch])
        2'd0:    mux_q <= ext_q;
        2'd1:    mux_q <= demod_q;
        default: mux_q <= '0;  // unused sources park at zero
      endcase
    end

    always_ff @(posedge ck933 or posedge rs) begin
      if (rs)
        out_q <= {1'b1, {MSB{1'b0}}};  // midscale
      else
        out_q <= {~mux_q[MSB], mux_q[MSB-1:0]};  // two's complement to offset binary
    end

    assign dac_d_o[ch] = out_q;
  end

endmodule

`default_nettype wire

//--- source/decoder_source_select.sv
`timescale 1ns/1ps
`default_nettype none

module decoder_source_select (
  input  wire logic                         ck933,
  input  wire logic                         rs,
  input  wire subcarrier_pkg::route_cfg_t   route_cfg_i,
  input  wire subcarrier_pkg::sym_bundle_t  ext_sym_i,
  input  wire subcarrier_pkg::sym_bundle_t  demod_sym_i,
  output subcarrier_pkg::sym_bundle_t       dec_sym_o
);
  import subcarrier_pkg::*;

  sym_bundle_t ext_q;
  sym_bundle_t demod_q;

  // reclock both sources as whole bundles so enables track their bits
  always_ff @(posedge ck933) begin
    ext_q   <= ext_sym_i;
    demod_q <= demod_sym_i;
  end

  always_ff @(posedge ck933 or posedge rs) begin
    if (rs)
      dec_sym_o <= '0;  // no stray symbol enables out of reset
    else if (route_cfg_i.dec_from_demod)
      dec_sym_o <= demod_q;
    else
      dec_sym_o <= ext_q;
  end

endmodule

`default_nettype wire

//--- source/reset_stretch.sv
`timescale 1ns/1ps
`default_nettype none
`include "subcarrier_macros.svh"

module reset_stretch (
  input  wire logic  ck933,
  input  wire logic  rs,
  input  wire logic  soft_rst_req_i,
  output logic       dac_rst_o
);

  localparam int CNT_W = $clog2(`SC_RESET_STRETCH + 1);

  logic [CNT_W-1:0] cnt;

  always_ff @(posedge ck933 or posedge rs) begin
    if (rs)
      cnt <= '0;
    else if (soft_rst_req_i)
      cnt <= CNT_W'(`SC_RESET_STRETCH);  // restart on every request
    else if (cnt != '0)
      cnt <= cnt - 1'b1;
  end

  assign dac_rst_o = (cnt != '0);

  // without a fresh request the dac reset ends after the stretch
  a_stretch_len: assert property (@(posedge ck933) disable iff (rs)
    (dac_rst_o && !soft_rst_req_i) [*`SC_RESET_STRETCH] |=> !dac_rst_o);

endmodule

`default_nettype wire

//--- source/subcarrier_csr.sv
`timescale 1ns/1ps
`default_nettype none
`include "subcarrier_macros.svh"

module subcarrier_csr (
  input  wire logic                       ck933,
  input  wire logic                       rs,
  input  wire subcarrier_pkg::axil_req_t  s_axil_req_i,
  output subcarrier_pkg::axil_rsp_t       s_axil_rsp_o,
  output subcarrier_pkg::route_cfg_t      route_cfg_o,
  output logic                            soft_rst_req_o,
  output subcarrier_pkg::boot_addr_t      boot_addr_o,
  output logic                            reboot_o
);
  import subcarrier_pkg::*;

  csr_state_e  state;
  logic        wr_pend;
  logic        wr_hs;
  logic        rd_hs;
  axil_data_t  rd_word;
  axil_data_t  rdata_q;
  route_cfg_t  cfg_q;
  boot_addr_t  boot_q;

  // **********************************************************
  // handshake, one transaction at a time
  // **********************************************************
  assign wr_pend = s_axil_req_i.awvalid | s_axil_req_i.wvalid;
  assign wr_hs   = (state == CSR_IDLE) && s_axil_req_i.awvalid && s_axil_req_i.wvalid;
  assign rd_hs   = (state == CSR_IDLE) && s_axil_req_i.arvalid && !wr_pend;  // write wins

  always_ff @(posedge ck933 or posedge rs) begin
    if (rs) begin
      state <= CSR_IDLE;
    end else begin
      case (state)
        CSR_IDLE: begin
          if (wr_hs)
            state <= CSR_WRESP;
          else if (rd_hs)
            state <= CSR_RRESP;
        end
        CSR_WRESP: if (s_axil_req_i.bready) state <= CSR_IDLE;  // hold until taken
        CSR_RRESP: if (s_axil_req_i.rready) state <= CSR_IDLE;
        default:   state <= CSR_IDLE;
      endcase
    end
  end

  // **********************************************************
  // register writes and pulses
  // **********************************************************
  always_ff @(posedge ck933 or posedge rs) begin
    if (rs) begin
      cfg_q          <= '0;
      boot_q         <= '0;
      soft_rst_req_o <= 1'b0;
      reboot_o       <= 1'b0;
    end else begin
      soft_rst_req_o <= 1'b0;
      reboot_o       <= 1'b0;
      if (wr_hs) begin
        case (s_axil_req_i.awaddr)
          `SC_REG_RESET: soft_rst_req_o <= 1'b1;  // data ignored
          `SC_REG_DAC_SEL: begin
            cfg_q.dac0_src <= s_axil_req_i.wdata[1:0];
            cfg_q.dac1_src <= s_axil_req_i.wdata[3:2];
            cfg_q.dac2_src <= s_axil_req_i.wdata[5:4];
          end
          `SC_REG_DEC_SEL: cfg_q.dec_from_demod <= s_axil_req_i.wdata[0];
          `SC_REG_REBOOT: begin
            for (int b = 0; b < `SC_BOOT_W/8; b++) begin
              if (s_axil_req_i.wstrb[b])
                boot_q[8*b +: 8] <= s_axil_req_i.wdata[8*b +: 8];
            end
            reboot_o <= s_axil_req_i.wstrb[2];  // upper byte fires the reboot
          end
          default: ;
        endcase
      end
    end
  end

  // read mux, DAC_SEL and DEC_SEL share one word
  always_comb begin
    case (s_axil_req_i.araddr)
      `SC_REG_VERSION: rd_word = {`SC_VERSION, 16'h0000};
      `SC_REG_DAC_SEL,
      `SC_REG_DEC_SEL: rd_word = {15'd0, cfg_q.dec_from_demod, 10'd0,
                                  cfg_q.dac2_src, cfg_q.dac1_src, cfg_q.dac0_src};
      `SC_REG_REBOOT:  rd_word = {8'd0, boot_q};
      default:         rd_word = '0;
    endcase
  end

  always_ff @(posedge ck933) begin
    if (rd_hs)
      rdata_q <= rd_word;
  end

  always_comb begin
    s_axil_rsp_o         = '0;  // bresp and rresp stay OKAY
    s_axil_rsp_o.awready = wr_hs;
    s_axil_rsp_o.wready  = wr_hs;
    s_axil_rsp_o.bvalid  = (state == CSR_WRESP);
    s_axil_rsp_o.arready = rd_hs;
    s_axil_rsp_o.rvalid  = (state == CSR_RRESP);
    s_axil_rsp_o.rdata   = rdata_q;
  end

  assign route_cfg_o = cfg_q;
  assign boot_addr_o = boot_q;

  // only one response channel active at a time
  a_resp_excl: assert property (@(posedge ck933) disable iff (rs)
    !(s_axil_rsp_o.bvalid && s_axil_rsp_o.rvalid));

  // reboot is a single-cycle strobe
  a_reboot_pulse: assert property (@(posedge ck933) disable iff (rs)
    reboot_o |=> !reboot_o);

endmodule

`default_nettype wire

//--- source/subcarrier_pkg.sv
`default_nettype none
`include "subcarrier_macros.svh"

package subcarrier_pkg;

  typedef logic [`SC_ADDR_W-1:0] axil_addr_t;
  typedef logic [`SC_DATA_W-1:0] axil_data_t;
  typedef logic [`SC_DAC_W-1:0]  dac_word_t;
  typedef logic [1:0]            dac_src_t;   // 0 ext, 1 demod, 2/3 zero
  typedef logic [`SC_BOOT_W-1:0] boot_addr_t;

  // master side of the AXI4-Lite port
  typedef struct packed {
    axil_addr_t               awaddr;
    logic                     awvalid;
    axil_data_t               wdata;
    logic [`SC_DATA_W/8-1:0]  wstrb;
    logic                     wvalid;
    logic                     bready;
    axil_addr_t               araddr;
    logic                     arvalid;
    logic                     rready;
  } axil_req_t;

  // slave side of the AXI4-Lite port
  typedef struct packed {
    logic        awready;
    logic        wready;
    logic        bvalid;
    logic [1:0]  bresp;
    logic        arready;
    logic        rvalid;
    axil_data_t  rdata;
    logic [1:0]  rresp;
  } axil_rsp_t;

  typedef struct packed {
    dac_src_t  dac0_src;
    dac_src_t  dac1_src;
    dac_src_t  dac2_src;
    logic      dec_from_demod;
  } route_cfg_t;

  // one decoder input symbol, bits plus their rate enables
  typedef struct packed {
    logic  i_bit;
    logic  q_bit;
    logic  sym_en;
    logic  sym2x_en;
  } sym_bundle_t;

  typedef enum logic [1:0] {
    CSR_IDLE,
    CSR_WRESP,
    CSR_RRESP
  } csr_state_e;

endpackage

`default_nettype wire

//--- source/subcarrier_top.sv
`timescale 1ns/1ps
`default_nettype none

module subcarrier_top (
  input  wire logic                         ck933,
  input  wire logic                         rs,
  input  wire subcarrier_pkg::axil_req_t    s_axil_req_i,
  output subcarrier_pkg::axil_rsp_t         s_axil_rsp_o,
  input  wire subcarrier_pkg::dac_word_t    ext_dac_i [3],
  input  wire subcarrier_pkg::dac_word_t    demod_dac_i [3],
  input  wire subcarrier_pkg::sym_bundle_t  ext_sym_i,
  input  wire subcarrier_pkg::sym_bundle_t  demod_sym_i,
  output subcarrier_pkg::dac_word_t         dac_d_o [3],
  output logic                              dac_rst_o,
  output subcarrier_pkg::sym_bundle_t       dec_sym_o,
  output subcarrier_pkg::boot_addr_t        boot_addr_o,
  output logic                              reboot_o
);
  import subcarrier_pkg::*;

  route_cfg_t route_cfg;
  logic       soft_rst_req;

  subcarrier_csr u_csr (
    .ck933          (ck933),
    .rs             (rs),
    .s_axil_req_i   (s_axil_req_i),
    .s_axil_rsp_o   (s_axil_rsp_o),
    .route_cfg_o    (route_cfg),
    .soft_rst_req_o (soft_rst_req),
    .boot_addr_o    (boot_addr_o),
    .reboot_o       (reboot_o)
  );

  dac_output_stage u_dac (
    .ck933       (ck933),
    .rs          (rs),
    .route_cfg_i (route_cfg),
    .ext_dac_i   (ext_dac_i),
    .demod_dac_i (demod_dac_i),
    .dac_d_o     (dac_d_o)
  );

  decoder_source_select u_dec_sel (
    .ck933       (ck933),
    .rs          (rs),
    .route_cfg_i (route_cfg),
    .ext_sym_i   (ext_sym_i),
    .demod_sym_i (demod_sym_i),
    .dec_sym_o   (dec_sym_o)
  );

  reset_stretch u_rst_stretch (
    .ck933          (ck933),
    .rs             (rs),
    .soft_rst_req_i (soft_rst_req),
    .dac_rst_o      (dac_rst_o)
  );

endmodule

`default_nettype wire
